// ==== apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    ////////////////////////////////////////////////////////////
    // apb bundles, one per direction
    ////////////////////////////////////////////////////////////

    // master to slave
    // paddr is a byte address, 4 registers on word boundaries
    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to master
    // no wait states, pready stays high
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== dist_pkg.sv ====
`default_nettype none

package dist_pkg;

    // payload width, tied to the apb data bus
    localparam int DIST_DW = 32;

    ////////////////////////////////////////////////////////////
    // switch commands
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CMD_IDLE        = 2'd0,   // drop
        CMD_BRANCH_LOW  = 2'd1,   // low side only
        CMD_BRANCH_HIGH = 2'd2,   // high side only
        CMD_DUPLICATE   = 2'd3    // both sides
    } dist_cmd_e;

    // one beat on every fifo and tree edge
    typedef struct packed {
        logic               valid;
        logic [DIST_DW-1:0] data;
    } dist_beat_t;

    ////////////////////////////////////////////////////////////
    // register map, byte addresses
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,   // bit 0 enable
        REG_ROUTE  = 4'h4,   // 2 bits per switch
        REG_DATA   = 4'h8,   // write only, pushes a word
        REG_STATUS = 4'hC    // count, empty, full
    } dist_reg_e;

endpackage

`default_nettype wire

// ==== dist_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_fifo
    import dist_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  wire logic        clk,
    input  wire logic        i_arst_n,
    input  wire dist_beat_t  i_push,
    input  wire logic        i_pop,
    output dist_beat_t       o_head,
    output logic             o_full,
    output logic             o_empty,
    output logic [15:0]      o_count
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DIST_DW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr_q;
    logic [AW-1:0]      rd_ptr_q;
    logic [15:0]        count_q;
    logic               do_push;
    logic               do_pop;

    // wrap at depth, depth need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_full  = (count_q == 16'(FIFO_DEPTH));
    assign o_empty = (count_q == 16'd0);
    assign o_count = count_q;

    // overflow and underflow are ignored
    assign do_push = i_push.valid & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    ////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr_q] <= i_push.data;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop)
            begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // push and pop together keep the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 16'd1;
                2'b01:   count_q <= count_q - 16'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    // oldest word, valid while not empty
    assign o_head = '{valid: ~o_empty, data: mem[rd_ptr_q]};

endmodule

`default_nettype wire

// ==== distribute_switch_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module distribute_switch_seq
    import dist_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_arst_n,
    input  wire dist_beat_t  i_beat,
    input  wire dist_cmd_e   i_cmd,
    output dist_beat_t       o_high,
    output dist_beat_t       o_low
);

    logic               sel_high;
    logic               sel_low;
    logic               high_vld_q;
    logic               low_vld_q;
    logic [DIST_DW-1:0] data_q;

    // command to side select
    assign sel_high = (i_cmd == CMD_BRANCH_HIGH) || (i_cmd == CMD_DUPLICATE);
    assign sel_low  = (i_cmd == CMD_BRANCH_LOW) || (i_cmd == CMD_DUPLICATE);

    // side valids, idle drops the beat
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            high_vld_q <= 1'b0;
            low_vld_q  <= 1'b0;
        end
        else
        begin
            high_vld_q <= i_beat.valid & sel_high;
            low_vld_q  <= i_beat.valid & sel_low;
        end
    end

    // one data register feeds both sides unchanged
    always_ff @(posedge clk)
    begin
        if (i_beat.valid)
        begin
            data_q <= i_beat.data;
        end
    end

    assign o_high = '{valid: high_vld_q, data: data_q};
    assign o_low  = '{valid: low_vld_q, data: data_q};

endmodule

`default_nettype wire

// ==== dist_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_tree
    import dist_pkg::*;
#(
    parameter int LEVELS = 3
)
(
    input  wire logic                         clk,
    input  wire logic                         i_arst_n,
    input  wire dist_beat_t                   i_root,
    input  wire dist_cmd_e [(2**LEVELS)-2:0]  i_route,
    output dist_beat_t [(2**LEVELS)-1:0]      o_leaf
);

    localparam int NUM_SW    = (2 ** LEVELS) - 1;
    // first switch of the last level, and its width
    localparam int LAST_BASE = (2 ** (LEVELS - 1)) - 1;
    localparam int LAST_CNT  = 2 ** (LEVELS - 1);

    dist_beat_t sw_in   [NUM_SW];
    dist_beat_t sw_high [NUM_SW];
    dist_beat_t sw_low  [NUM_SW];

    ////////////////////////////////////////////////////////////
    // switch heap
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_SW; i++) begin : g_sw
        // root takes the fifo beat
        if (i == 0) begin : g_root
            assign sw_in[i] = i_root;
        end
        // odd index is a high child
        else if (i % 2 == 1) begin : g_upper
            assign sw_in[i] = sw_high[(i - 1) / 2];
        end
        // even index is a low child
        else begin : g_lower
            assign sw_in[i] = sw_low[(i - 1) / 2];
        end

        distribute_switch_seq u_sw (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .i_beat   (sw_in[i]),
            .i_cmd    (i_route[i]),
            .o_high   (sw_high[i]),
            .o_low    (sw_low[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // last level to leaves
    ////////////////////////////////////////////////////////////

    // switch k feeds leaf 2k from high, 2k+1 from low
    for (genvar k = 0; k < LAST_CNT; k++) begin : g_leaf
        assign o_leaf[2*k]     = sw_high[LAST_BASE + k];
        assign o_leaf[2*k + 1] = sw_low[LAST_BASE + k];
    end

endmodule

`default_nettype wire

// ==== dist_cfg_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_cfg_apb
    import apb_pkg::*;
    import dist_pkg::*;
#(
    parameter int LEVELS     = 3,
    parameter int FIFO_DEPTH = 8
)
(
    input  wire logic                          clk,
    input  wire logic                          i_arst_n,
    input  wire apb_req_t                      i_apb,
    input  wire logic                          i_fifo_full,
    input  wire logic                          i_fifo_empty,
    input  wire logic [15:0]                   i_fifo_count,
    output apb_rsp_t                           o_apb,
    output dist_beat_t                         o_push,
    output logic                               o_enable,
    output dist_cmd_e [(2**LEVELS)-2:0]        o_route
);

    localparam int NUM_SW = (2 ** LEVELS) - 1;
    localparam int RW     = 2 * NUM_SW;

    // route register must fit 32 bits, count must fit 16 bits
    if (LEVELS < 1 || LEVELS > 4) begin : g_bad_levels
        $error("dist_cfg_apb: LEVELS must be 1 to 4");
    end
    if (FIFO_DEPTH < 2 || FIFO_DEPTH > 65535) begin : g_bad_depth
        $error("dist_cfg_apb: FIFO_DEPTH out of range");
    end

    ////////////////////////////////////////////////////////////
    // access phase decode
    ////////////////////////////////////////////////////////////

    logic            access;
    logic            wr_acc;
    dist_reg_e       reg_addr;
    logic            data_wr;
    logic [RW-1:0]   route_q;
    logic            enable_q;
    logic [31:0]     rd_data;
    logic            slv_err;

    // second cycle of a transfer
    assign access   = i_apb.psel & i_apb.penable;
    assign wr_acc   = access & i_apb.pwrite;
    assign reg_addr = dist_reg_e'(i_apb.paddr);
    assign data_wr  = wr_acc & (reg_addr == REG_DATA);

    // control registers
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            enable_q <= 1'b0;
            route_q  <= '0;
        end
        else
        begin
            if (wr_acc && reg_addr == REG_CTRL)
            begin
                enable_q <= i_apb.pwdata[0];
            end
            if (wr_acc && reg_addr == REG_ROUTE)
            begin
                route_q <= i_apb.pwdata[RW-1:0];
            end
        end
    end

    // readback and error decode
    always_comb
    begin
        rd_data = '0;
        slv_err = 1'b0;
        case (reg_addr)
            REG_CTRL:   rd_data = {31'b0, enable_q};
            REG_ROUTE:  rd_data = 32'(route_q);
            // write only, and full drops the word
            REG_DATA:   slv_err = ~i_apb.pwrite | i_fifo_full;
            // read only
            REG_STATUS:
            begin
                rd_data = {14'b0, i_fifo_full, i_fifo_empty, i_fifo_count};
                slv_err = i_apb.pwrite;
            end
            // unmapped address
            default:    slv_err = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign o_apb = '{prdata:  (access & ~i_apb.pwrite) ? rd_data : 32'b0,
                     pready:  1'b1,
                     pslverr: access & slv_err};

    // one beat per accepted data write
    assign o_push   = '{valid: data_wr & ~i_fifo_full, data: i_apb.pwdata};
    assign o_enable = enable_q;

    // switch i takes bits 2i+1:2i
    for (genvar i = 0; i < NUM_SW; i++) begin : g_route
        assign o_route[i] = dist_cmd_e'(route_q[2*i +: 2]);
    end

endmodule

`default_nettype wire

// ==== dist_net_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_net_top
    import apb_pkg::*;
    import dist_pkg::*;
#(
    parameter int LEVELS     = 3,
    parameter int FIFO_DEPTH = 8
)
(
    input  wire logic                     clk,
    input  wire logic                     i_arst_n,
    input  wire apb_req_t                 i_apb,
    output apb_rsp_t                      o_apb,
    output dist_beat_t [(2**LEVELS)-1:0]  o_leaf
);

    dist_beat_t                    push_beat;
    dist_beat_t                    fifo_head;
    dist_beat_t                    root_beat;
    logic                          fifo_full;
    logic                          fifo_empty;
    logic [15:0]                   fifo_count;
    logic                          enable;
    logic                          fifo_pop;
    dist_cmd_e [(2**LEVELS)-2:0]   route;

    ////////////////////////////////////////////////////////////
    // producer
    ////////////////////////////////////////////////////////////

    dist_cfg_apb #(
        .LEVELS     (LEVELS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cfg (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_apb        (i_apb),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .i_fifo_count (fifo_count),
        .o_apb        (o_apb),
        .o_push       (push_beat),
        .o_enable     (enable),
        .o_route      (route)
    );

    // buffer
    dist_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (push_beat),
        .i_pop    (fifo_pop),
        .o_head   (fifo_head),
        .o_full   (fifo_full),
        .o_empty  (fifo_empty),
        .o_count  (fifo_count)
    );

    // enable gates the pop, nothing else downstream
    assign fifo_pop  = enable & fifo_head.valid;
    assign root_beat = '{valid: fifo_pop, data: fifo_head.data};

    // consumer
    dist_tree #(
        .LEVELS (LEVELS)
    ) u_tree (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_root   (root_beat),
        .i_route  (route),
        .o_leaf   (o_leaf)
    );

endmodule

`default_nettype wire

// ==== dist_net_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_net_sva
    import apb_pkg::*;
    import dist_pkg::*;
#(
    parameter int LEVELS = 3
)
(
    input  wire logic                          clk,
    input  wire logic                          i_arst_n,
    input  wire apb_req_t                      i_apb,
    input  wire apb_rsp_t                      i_apb_rsp,
    input  wire dist_beat_t [(2**LEVELS)-1:0]  i_leaf
);

    localparam int NUM_LEAF = 2 ** LEVELS;

    logic [NUM_LEAF-1:0] leaf_vld;
    logic [7:0]          since_rst;

    // flatten leaf valids
    for (genvar l = 0; l < NUM_LEAF; l++) begin : g_vld
        assign leaf_vld[l] = i_leaf[l].valid;
    end

    // edges since reset release, saturates at LEVELS
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            since_rst <= '0;
        end
        else if (since_rst < 8'(LEVELS))
        begin
            since_rst <= since_rst + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // apb response
    ////////////////////////////////////////////////////////////

    // no wait states
    a_pready_high : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_apb_rsp.pready)
        else $error("pready dropped low");

    // error only in the second cycle of a transfer
    a_slverr_access : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_apb_rsp.pslverr |-> (i_apb.psel && i_apb.penable))
        else $error("pslverr outside an access cycle");

    // a beat needs LEVELS edges to cross the tree
    a_leaf_quiet : assert property (@(posedge clk) disable iff (!i_arst_n)
        (since_rst < 8'(LEVELS)) |-> (leaf_vld == '0))
        else $error("leaf valid too early after reset");

endmodule

bind dist_net_top dist_net_sva #(
    .LEVELS (LEVELS)
) u_sva (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_apb     (i_apb),
    .i_apb_rsp (o_apb),
    .i_leaf    (o_leaf)
);

`default_nettype wire

// ==== dist_net_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dist_net_tb
    import apb_pkg::*;
    import dist_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int LEVELS     = 3;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_SW     = (2 ** LEVELS) - 1;
    localparam int NUM_LEAF   = 2 ** LEVELS;
    localparam int LAST_BASE  = (2 ** (LEVELS - 1)) - 1;
    localparam logic [31:0] ROUTE_MASK = (32'd1 << (2 * NUM_SW)) - 32'd1;
    // about 300 transfers at 3 cycles, status polls and drain, wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                      clk;
    logic                      arst_n;
    apb_req_t                  apb_req;
    apb_rsp_t                  apb_rsp;
    dist_beat_t [NUM_LEAF-1:0] leaf;

    logic [31:0] rng_state;
    logic [31:0] cur_route;
    // expected words per leaf, oldest first
    logic [31:0] exp_q [NUM_LEAF][$];
    string       test_name;
    int          mismatch_cnt;
    int          other_cnt;
    int          cycle_cnt;

    dist_net_top #(
        .LEVELS     (LEVELS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk      (clk),
        .i_arst_n (arst_n),
        .i_apb    (apb_req),
        .o_apb    (apb_rsp),
        .o_leaf   (leaf)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // run limit
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // walk the heap from the root, one command per switch
    function automatic logic [NUM_LEAF-1:0] leaf_mask(input logic [31:0] route);
        logic [NUM_SW-1:0]   reach;
        logic [NUM_LEAF-1:0] mask;
        dist_cmd_e           cmd;
        logic                go_high;
        logic                go_low;
        reach    = '0;
        mask     = '0;
        reach[0] = 1'b1;
        for (int i = 0; i < NUM_SW; i++)
        begin
            cmd     = dist_cmd_e'(route[2*i +: 2]);
            go_high = reach[i] && (cmd == CMD_BRANCH_HIGH || cmd == CMD_DUPLICATE);
            go_low  = reach[i] && (cmd == CMD_BRANCH_LOW || cmd == CMD_DUPLICATE);
            // high child 2i+1, low child 2i+2
            if (i < LAST_BASE)
            begin
                reach[2*i + 1] = go_high;
                reach[2*i + 2] = go_low;
            end
            // last level, switch k feeds leaves 2k and 2k+1
            else
            begin
                mask[2*(i - LAST_BASE)]     = go_high;
                mask[2*(i - LAST_BASE) + 1] = go_low;
            end
        end
        return mask;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual)
        begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // setup, access, then idle; response sampled mid access
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    // accepted words are expected on every selected leaf
    task automatic push_word(input logic [31:0] word, output logic err);
        logic [31:0]         rdata;
        logic [NUM_LEAF-1:0] mask;
        apb_xfer(1'b1, REG_DATA, word, rdata, err);
        mask = leaf_mask(cur_route);
        if (!err)
        begin
            for (int l = 0; l < NUM_LEAF; l++)
            begin
                if (mask[l])
                begin
                    exp_q[l].push_back(word);
                end
            end
        end
    endtask

    task automatic set_route(input logic [31:0] route);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_ROUTE, route, rdata, err);
        compare_value({test_name, " route pslverr"}, 32'd0, 32'(err));
        cur_route = route;
    endtask

    task automatic set_enable(input logic en);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, REG_CTRL, 32'(en), rdata, err);
        compare_value({test_name, " ctrl pslverr"}, 32'd0, 32'(err));
    endtask

    // poll until the fifo is empty, then let the tree flush
    task automatic wait_drain();
        logic [31:0] status;
        logic        err;
        status = '0;
        while (!status[16])
        begin
            apb_xfer(1'b0, REG_STATUS, '0, status, err);
        end
        repeat (LEVELS + 1) @(negedge clk);
    endtask

    task automatic run_uniform(input dist_cmd_e cmd, input logic [NUM_LEAF-1:0] exp_mask);
        logic [31:0] route;
        logic        err;
        route = '0;
        for (int i = 0; i < NUM_SW; i++)
        begin
            route[2*i +: 2] = cmd;
        end
        // reference against the plain rule for this shape
        compare_value({test_name, " mask"}, 32'(exp_mask), 32'(leaf_mask(route)));
        set_route(route);
        for (int n = 0; n < 4; n++)
        begin
            rng_state = xorshift32(rng_state);
            push_word(rng_state, err);
            compare_value({test_name, " pslverr"}, 32'd0, 32'(err));
        end
        wait_drain();
    endtask

    ////////////////////////////////////////////////////////////
    // leaf monitor
    ////////////////////////////////////////////////////////////

    // leaves are registered, stable at the falling edge
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            for (int l = 0; l < NUM_LEAF; l++)
            begin
                if (leaf[l].valid)
                begin
                    if (exp_q[l].size() == 0)
                    begin
                        other_cnt++;
                        $display("leaf %0d delivered %h with no word expected", l,
                                 leaf[l].data);
                    end
                    else
                    begin
                        compare_value($sformatf("%s leaf %0d", test_name, l),
                                      exp_q[l].pop_front(), leaf[l].data);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        logic [31:0] rdata;
        logic        err;
        arst_n       = 1'b0;
        apb_req      = '0;
        rng_state    = 32'd48629;
        cur_route    = '0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // reset values, idle route drops everything
        apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
        compare_value("reset ctrl", 32'd0, rdata);
        apb_xfer(1'b0, REG_ROUTE, '0, rdata, err);
        compare_value("reset route", 32'd0, rdata);
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        compare_value("reset status", 32'h0001_0000, rdata);
        set_enable(1'b1);
        push_word(32'hA5A5_0001, err);
        compare_value("reset push pslverr", 32'd0, 32'(err));
        wait_drain();

        test_name = "uniform high";
        run_uniform(CMD_BRANCH_HIGH, 8'h01);
        test_name = "uniform low";
        run_uniform(CMD_BRANCH_LOW, 8'h80);
        test_name = "uniform duplicate";
        run_uniform(CMD_DUPLICATE, 8'hFF);

        // new route only on a drained tree
        test_name = "random route";
        for (int r = 0; r < 20; r++)
        begin
            rng_state = xorshift32(rng_state);
            set_route(rng_state & ROUTE_MASK);
            for (int n = 0; n < 10; n++)
            begin
                rng_state = xorshift32(rng_state);
                push_word(rng_state, err);
                compare_value("random route pslverr", 32'd0, 32'(err));
            end
            wait_drain();
        end

        // fill past depth with the pop held off
        test_name = "overflow";
        set_enable(1'b0);
        set_route(ROUTE_MASK);
        for (int n = 0; n < FIFO_DEPTH + 2; n++)
        begin
            rng_state = xorshift32(rng_state);
            push_word(rng_state, err);
            compare_value("overflow pslverr", (n >= FIFO_DEPTH) ? 32'd1 : 32'd0, 32'(err));
        end
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        compare_value("overflow status", 32'h0002_0000 | 32'(FIFO_DEPTH), rdata);
        set_enable(1'b1);
        wait_drain();

        // bad accesses leave state alone
        // enable and route still hold what the overflow test wrote
        test_name = "register errors";
        apb_xfer(1'b0, REG_DATA, '0, rdata, err);
        compare_value("data read pslverr", 32'd1, 32'(err));
        rng_state = xorshift32(rng_state);
        apb_xfer(1'b1, REG_STATUS, rng_state, rdata, err);
        compare_value("status write pslverr", 32'd1, 32'(err));
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        compare_value("status after errors", 32'h0001_0000, rdata);
        apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
        compare_value("ctrl after errors", 32'd1, rdata);
        apb_xfer(1'b0, REG_ROUTE, '0, rdata, err);
        compare_value("route after errors", cur_route, rdata);
        rng_state = xorshift32(rng_state);
        set_route(rng_state & ROUTE_MASK);
        apb_xfer(1'b0, REG_ROUTE, '0, rdata, err);
        compare_value("route readback", cur_route, rdata);

        for (int l = 0; l < NUM_LEAF; l++)
        begin
            if (exp_q[l].size() != 0)
            begin
                other_cnt++;
                $display("leaf %0d never delivered %0d expected words", l, exp_q[l].size());
            end
        end
        $display("closing: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dist_net.f ====
apb_pkg.sv
dist_pkg.sv
dist_fifo.sv
distribute_switch_seq.sv
dist_tree.sv
dist_cfg_apb.sv
dist_net_top.sv
dist_net_sva.sv
dist_net_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the distribution network testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module dist_net_tb \
    -f dist_net.f \
    -o sim_dist_net

./obj_dir/sim_dist_net > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
